// File: io_cases.txt
# op sel data expected, all hex. write: sel=index, expected={size,byte_off}, 8=word
# read: expected=rd_data. set/pulse: sel=port. wait: sel=output, data=timeout cycles
write 07 0000ffff 8
read 28 0 0000fff0
write 0e 0000a5a5 8
write 0e 00003c00 1
read 28 0 00003ca5
write 12 00007f00 8
write 13 00001200 8
read 32 0 00007f00
read 33 0 00001200
write 02 11223344 8
write 03 05667788 8
write 04 0000abcd 8
write 0a 00000009 8
wait 2 10 1
wait 3 10 95667788
wait 4 10 11223344
wait 5 10 0000abcd
set 5 3 0
write 02 cafef00d 8
wait 6 10 1
wait 4 10 cafef00d
wait 2 10 0
set 0 0 0
pulse 0 03 0
pulse 0 00 0
pulse 0 1f 0
pulse 0 0a 0
read 22 0 80000408
write 0c 00000003 8
read 22 0 80000400
write 08 00000000 8
read 22 0 00000000
write 14 00000001 8
pulse 1 12ab 0
pulse 1 13cd 0
pulse 1 7234 0
pulse 1 1255 0
pulse 1 0012 0
pulse 1 12ff 0
read 27 0 00000008
read 34 0 000012ab
write 15 00000001 8
read 34 0 00001255
write 15 00000001 8
read 34 0 000012ff
write 14 00000000 8
read 27 0 00000000
write 0e 0000fff2 8
set 6 a1b2c3d4 0
set 1 1 0
set 2 1 0
set 4 1 0
wait 0 10 1
read 27 0 00000212
read 20 0 a1b2c3d4
read 23 0 00000001
read 24 0 0000005a
write 0f 00000230 8
wait 7 0 7
set 1 0 0
set 2 0 0
set 4 0 0
write 0f 00000000 8
wait 0 10 0
write 0e 0000fff3 8
write 07 00000020 8
wait 1 40 1
write 0f 00000001 8
wait 1 5 0

// File: build.f
core_io_pkg.sv
msg_fifo.sv
io_write_regs.sv
event_unit.sv
io_read_irq.sv
core_io_block.sv
tb_core_io_block.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the core I/O block testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_core_io_block -o sim_tb
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx '>>> PASS'; then
  exit 0
else
  exit 1
fi

// File: tb_core_io_block.sv
`timescale 1ns/1ps

module tb_core_io_block;

  localparam int BC_ADDR_W = 15;
  localparam int TIMEOUT   = 50;

  logic                 clk;
  logic                 rst;
  core_io_pkg::io_cmd_t cmd;
  logic                 cmd_ready;
  logic                 rd_valid;
  logic [31:0]          rd_data;
  core_io_pkg::desc_t   in_desc;
  logic                 in_desc_valid;
  logic                 in_desc_taken;
  core_io_pkg::desc_t   out_desc;
  logic                 out_desc_valid;
  logic [63:0]          out_desc_dram_addr;
  logic                 out_desc_ready;
  logic [7:0]           core_id;
  logic [63:0]          timer;
  logic                 core_msg_ready;
  logic [BC_ADDR_W-1:0] bc_addr_in;
  logic                 bc_valid_in;
  logic                 bc_ovf_err;
  logic [31:0]          slot_wr_data;
  logic                 slot_wr_valid;
  logic                 slot_wr_ready;
  logic [63:0]          debug_out;
  logic                 debug_l_valid;
  logic                 debug_h_valid;
  logic                 poke_int;
  logic                 poke_ack;
  logic                 evict_int;
  logic                 evict_ack;
  logic                 ext_io_err;
  logic                 ext_io_err_ack;
  logic [4:0]           recv_tag;
  logic                 recv_tag_valid;
  logic                 core_irq;
  logic                 timer_irq;

  int         errors;
  int         timeouts;
  int         seed;
  int         ready_delay;
  logic       stalled;
  logic [2:0] ack_seen;

  core_io_block #(
    .BC_ADDR_W  (BC_ADDR_W),
    .BC_FIFO_AW (4)
  ) dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Bus and port operations
  ////////////////////////////////////////////////////////////

  // acc holds {size, byte_off}, 8 is a full word
  task automatic write_reg(input logic [31:0] idx, input logic [31:0] data,
                           input logic [31:0] acc);
    int         n;
    logic [3:0] strb_exp;
    @(negedge clk);
    cmd.valid    = 1'b1;
    cmd.wen      = 1'b1;
    cmd.idx      = idx[5:0];
    cmd.size     = acc[3:2];
    cmd.byte_off = acc[1:0];
    cmd.wr_data  = data;
    stalled      = 1'b0;
    n            = 0;
    #1;
    while (!cmd_ready && n < TIMEOUT) begin
      stalled = 1'b1;
      @(negedge clk);
      n++;
      // Consumer takes the pending descriptor after a set delay
      if (n == ready_delay)
        out_desc_ready = 1'b1;
      #1;
    end
    assert (cmd_ready) else begin
      timeouts++;
      $display("timeout: write to index %0h was never accepted", idx);
    end
    ack_seen = ack_seen | {ext_io_err_ack, evict_ack, poke_ack};
    // Strobe writes pulse only with data bit 0 set, debug valids follow a cycle later
    strb_exp[0] = cmd_ready && (idx[5:0] == core_io_pkg::SLOT_STRB) && data[0];
    strb_exp[1] = cmd_ready && (idx[5:0] == core_io_pkg::RD_DESC_STRB) && data[0];
    strb_exp[2] = cmd_ready && (idx[5:0] == core_io_pkg::DEBUG_L);
    strb_exp[3] = cmd_ready && (idx[5:0] == core_io_pkg::DEBUG_H);
    assert ({in_desc_taken, slot_wr_valid} === strb_exp[1:0]) else begin
      errors++;
      $display("error at %0t: write to index %0h gave strobes %b, expected %b",
               $time, idx, {in_desc_taken, slot_wr_valid}, strb_exp[1:0]);
    end
    ready_delay = 0;
    @(negedge clk);
    assert ({debug_h_valid, debug_l_valid} === strb_exp[3:2]) else begin
      errors++;
      $display("error at %0t: write to index %0h gave debug valids %b, expected %b",
               $time, idx, {debug_h_valid, debug_l_valid}, strb_exp[3:2]);
    end
    cmd.valid = 1'b0;
    cmd.wen   = 1'b0;
  endtask

  task automatic read_reg(input logic [31:0] idx, input logic [31:0] exp);
    @(negedge clk);
    cmd.valid = 1'b1;
    cmd.wen   = 1'b0;
    cmd.idx   = idx[5:0];
    @(negedge clk);
    cmd.valid = 1'b0;
    // Read data is registered, so it is stable here
    assert (rd_valid === 1'b1 && rd_data === exp) else begin
      errors++;
      $display("error at %0t: read of index %0h gave %h (valid %b), expected %h",
               $time, idx, rd_data, rd_valid, exp);
    end
    // The overflow flag bit is the sticky error output
    if (idx[5:0] == core_io_pkg::RD_INT_FLAGS) begin
      assert (bc_ovf_err === exp[core_io_pkg::INT_BC_OVF]) else begin
        errors++;
        $display("error at %0t: bc_ovf_err is %b, expected %b",
                 $time, bc_ovf_err, exp[core_io_pkg::INT_BC_OVF]);
      end
    end
  endtask

  task automatic set_input(input logic [31:0] sel, input logic [31:0] data);
    @(negedge clk);
    case (sel)
      0: out_desc_ready = data[0];
      1: in_desc_valid  = data[0];
      2: poke_int       = data[0];
      3: evict_int      = data[0];
      4: ext_io_err     = data[0];
      5: ready_delay    = data;
      6: in_desc        = {32'd0, data};
      default: begin
        errors++;
        $display("unknown input selector %0d in the case file", sel);
      end
    endcase
  endtask

  task automatic pulse_input(input logic [31:0] sel, input logic [31:0] data);
    @(negedge clk);
    if (sel == 0) begin
      recv_tag       = data[4:0];
      recv_tag_valid = 1'b1;
    end else begin
      bc_addr_in  = data[BC_ADDR_W-1:0];
      bc_valid_in = 1'b1;
    end
    @(negedge clk);
    recv_tag_valid = 1'b0;
    bc_valid_in    = 1'b0;
  endtask

  function automatic logic [31:0] watched(input logic [31:0] sel);
    case (sel)
      0: return {31'd0, core_irq};
      1: return {31'd0, timer_irq};
      2: return {31'd0, out_desc_valid};
      3: return out_desc[63:32];
      4: return out_desc[31:0];
      5: return out_desc_dram_addr[31:0];
      6: return {31'd0, stalled};
      7: return {29'd0, ack_seen};
      default: return 32'hffff_ffff;
    endcase
  endfunction

  task automatic wait_output(input logic [31:0] sel, input logic [31:0] limit,
                             input logic [31:0] exp);
    int n;
    n = 0;
    @(negedge clk);
    while (watched(sel) !== exp && n < limit) begin
      @(negedge clk);
      n++;
    end
    assert (watched(sel) === exp) else begin
      timeouts++;
      $display("timeout: output %0d did not reach %h within %0d cycles", sel, exp, limit);
    end
    if (sel == 7)
      ack_seen = 3'b000;
  endtask

  ////////////////////////////////////////////////////////////
  // Case file replay
  ////////////////////////////////////////////////////////////
  initial begin
    string       line;
    string       op;
    logic [31:0] sel;
    logic [31:0] data;
    logic [31:0] exp;
    int          fd;
    int          n;
    int          gap;

    errors         = 0;
    timeouts       = 0;
    seed           = 32'hf45e;
    ready_delay    = 0;
    stalled        = 1'b0;
    ack_seen       = 3'b000;
    rst            = 1'b1;
    cmd            = '0;
    in_desc        = '0;
    in_desc_valid  = 1'b0;
    out_desc_ready = 1'b0;
    core_id        = 8'h5a;
    timer          = 64'h0000_0012_3456_789a;
    core_msg_ready = 1'b0;
    bc_addr_in     = '0;
    bc_valid_in    = 1'b0;
    slot_wr_ready  = 1'b0;
    poke_int       = 1'b0;
    evict_int      = 1'b0;
    ext_io_err     = 1'b0;
    recv_tag       = '0;
    recv_tag_valid = 1'b0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    fd = $fopen("io_cases.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open io_cases.txt");
    end else begin
      while ($fgets(line, fd) != 0) begin
        n = $sscanf(line, "%s %h %h %h", op, sel, data, exp);
        if (line.getc(0) != 8'h23 && n == 4) begin
          // Idle gap between operations
          gap = $random(seed) & 3;
          repeat (gap) @(negedge clk);
          if (op == "write")
            write_reg(sel, data, exp);
          else if (op == "read")
            read_reg(sel, exp);
          else if (op == "set")
            set_input(sel, data);
          else if (op == "pulse")
            pulse_input(sel, data);
          else if (op == "wait")
            wait_output(sel, data, exp);
          else begin
            errors++;
            $display("unknown operation in the case file: %s", op);
          end
        end
      end
      $fclose(fd);
    end

    $display("errors: %0d  timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

// File: core_io_block.sv
`timescale 1ns/1ps

module core_io_block #(
  parameter int BC_ADDR_W  = 15,
  parameter int BC_FIFO_AW = 4
) (
  input  logic                 clk,
  input  logic                 rst,
  // Data-bus I/O commands
  input  core_io_pkg::io_cmd_t cmd,
  output logic                 cmd_ready,
  output logic                 rd_valid,
  output logic [31:0]          rd_data,
  // Descriptors
  input  core_io_pkg::desc_t   in_desc,
  input  logic                 in_desc_valid,
  output logic                 in_desc_taken,
  output core_io_pkg::desc_t   out_desc,
  output logic                 out_desc_valid,
  output logic [63:0]          out_desc_dram_addr,
  input  logic                 out_desc_ready,
  // Status
  input  logic [7:0]           core_id,
  input  logic [63:0]          timer,
  input  logic                 core_msg_ready,
  // Broadcast messages
  input  logic [BC_ADDR_W-1:0] bc_addr_in,
  input  logic                 bc_valid_in,
  output logic                 bc_ovf_err,
  // Slot info and debug
  output logic [31:0]          slot_wr_data,
  output logic                 slot_wr_valid,
  input  logic                 slot_wr_ready,
  output logic [63:0]          debug_out,
  output logic                 debug_l_valid,
  output logic                 debug_h_valid,
  // Interrupt sources and acks
  input  logic                 poke_int,
  output logic                 poke_ack,
  input  logic                 evict_int,
  output logic                 evict_ack,
  input  logic                 ext_io_err,
  output logic                 ext_io_err_ack,
  input  logic [4:0]           recv_tag,
  input  logic                 recv_tag_valid,
  output logic                 core_irq,
  output logic                 timer_irq
);

  core_io_pkg::io_ctl_t ctl;
  logic [15:0]          int_mask;
  logic [BC_ADDR_W-1:0] bc_mask;
  logic [BC_ADDR_W-1:0] bc_equal;
  logic                 bc_fifo_en;
  logic                 timer_int;
  logic [31:0]          dram_flags;
  logic                 dram_any;
  logic                 bc_valid;
  logic [BC_ADDR_W-1:0] bc_head;
  logic                 bc_ovf_event;

  io_write_regs #(
    .BC_ADDR_W (BC_ADDR_W)
  ) wr_regs (
    .clk                (clk),
    .rst                (rst),
    .cmd                (cmd),
    .out_desc_ready     (out_desc_ready),
    .cmd_ready          (cmd_ready),
    .ctl                (ctl),
    .int_mask           (int_mask),
    .bc_mask            (bc_mask),
    .bc_equal           (bc_equal),
    .bc_fifo_en         (bc_fifo_en),
    .out_desc           (out_desc),
    .out_desc_valid     (out_desc_valid),
    .out_desc_dram_addr (out_desc_dram_addr),
    .slot_wr_data       (slot_wr_data),
    .slot_wr_valid      (slot_wr_valid),
    .in_desc_taken      (in_desc_taken),
    .debug_out          (debug_out),
    .debug_l_valid      (debug_l_valid),
    .debug_h_valid      (debug_h_valid)
  );

  event_unit #(
    .BC_ADDR_W  (BC_ADDR_W),
    .BC_FIFO_AW (BC_FIFO_AW)
  ) events (
    .clk            (clk),
    .rst            (rst),
    .ctl            (ctl),
    .recv_tag       (recv_tag),
    .recv_tag_valid (recv_tag_valid),
    .bc_addr_in     (bc_addr_in),
    .bc_valid_in    (bc_valid_in),
    .bc_mask        (bc_mask),
    .bc_equal       (bc_equal),
    .bc_fifo_en     (bc_fifo_en),
    .timer_int      (timer_int),
    .dram_flags     (dram_flags),
    .dram_any       (dram_any),
    .bc_valid       (bc_valid),
    .bc_head        (bc_head),
    .bc_ovf_event   (bc_ovf_event)
  );

  io_read_irq #(
    .BC_ADDR_W (BC_ADDR_W)
  ) rd_irq (
    .clk            (clk),
    .rst            (rst),
    .cmd            (cmd),
    .ctl            (ctl),
    .int_mask       (int_mask),
    .bc_mask        (bc_mask),
    .bc_equal       (bc_equal),
    .timer_int      (timer_int),
    .dram_flags     (dram_flags),
    .dram_any       (dram_any),
    .bc_valid       (bc_valid),
    .bc_head        (bc_head),
    .bc_ovf_event   (bc_ovf_event),
    .in_desc        (in_desc),
    .in_desc_valid  (in_desc_valid),
    .poke_int       (poke_int),
    .evict_int      (evict_int),
    .ext_io_err     (ext_io_err),
    .out_desc_ready (out_desc_ready),
    .slot_wr_ready  (slot_wr_ready),
    .core_msg_ready (core_msg_ready),
    .core_id        (core_id),
    .timer          (timer),
    .rd_valid       (rd_valid),
    .rd_data        (rd_data),
    .core_irq       (core_irq),
    .timer_irq      (timer_irq),
    .poke_ack       (poke_ack),
    .evict_ack      (evict_ack),
    .ext_io_err_ack (ext_io_err_ack),
    .bc_ovf_err     (bc_ovf_err)
  );

endmodule

// File: io_read_irq.sv
`timescale 1ns/1ps

module io_read_irq #(
  parameter int BC_ADDR_W = 15
) (
  input  logic                 clk,
  input  logic                 rst,
  input  core_io_pkg::io_cmd_t cmd,
  input  core_io_pkg::io_ctl_t ctl,
  input  logic [15:0]          int_mask,
  input  logic [BC_ADDR_W-1:0] bc_mask,
  input  logic [BC_ADDR_W-1:0] bc_equal,
  input  logic                 timer_int,
  input  logic [31:0]          dram_flags,
  input  logic                 dram_any,
  input  logic                 bc_valid,
  input  logic [BC_ADDR_W-1:0] bc_head,
  input  logic                 bc_ovf_event,
  input  core_io_pkg::desc_t   in_desc,
  input  logic                 in_desc_valid,
  input  logic                 poke_int,
  input  logic                 evict_int,
  input  logic                 ext_io_err,
  input  logic                 out_desc_ready,
  input  logic                 slot_wr_ready,
  input  logic                 core_msg_ready,
  input  logic [7:0]           core_id,
  input  logic [63:0]          timer,
  output logic                 rd_valid,
  output logic [31:0]          rd_data,
  output logic                 core_irq,
  output logic                 timer_irq,
  output logic                 poke_ack,
  output logic                 evict_ack,
  output logic                 ext_io_err_ack,
  output logic                 bc_ovf_err
);

  logic [31:0] int_flags;
  logic        rd;

  ////////////////////////////////////////////////////////////
  // Interrupts
  ////////////////////////////////////////////////////////////
  always_comb begin
    int_flags                          = '0;
    int_flags[core_io_pkg::INT_TIMER]   = timer_int;
    int_flags[core_io_pkg::INT_IN_DESC] = in_desc_valid;
    int_flags[core_io_pkg::INT_DRAM]    = dram_any;
    int_flags[core_io_pkg::INT_BC_MSG]  = bc_valid;
    int_flags[core_io_pkg::INT_POKE]    = poke_int;
    int_flags[core_io_pkg::INT_EVICT]   = evict_int;
    int_flags[core_io_pkg::INT_BC_OVF]  = bc_ovf_err;
    int_flags[core_io_pkg::INT_EXT_IO]  = ext_io_err;
  end

  // Sources stay high until served, so the ack cycle masks the stale level
  always_ff @(posedge clk) begin
    if (rst) begin
      core_irq   <= 1'b0;
      bc_ovf_err <= 1'b0;
    end else begin
      core_irq   <= !ctl.int_ack && |(int_flags[15:1] & int_mask[15:1]);
      bc_ovf_err <= !(ctl.int_ack && ctl.wr_data[core_io_pkg::INT_BC_OVF]) &&
                    (bc_ovf_err || bc_ovf_event);
    end
  end

  assign timer_irq      = timer_int && int_mask[core_io_pkg::INT_TIMER];
  assign poke_ack       = ctl.int_ack && ctl.wr_data[core_io_pkg::INT_POKE];
  assign evict_ack      = ctl.int_ack && ctl.wr_data[core_io_pkg::INT_EVICT];
  assign ext_io_err_ack = ctl.int_ack && ctl.wr_data[core_io_pkg::INT_EXT_IO];

  ////////////////////////////////////////////////////////////
  // Register reads
  ////////////////////////////////////////////////////////////
  assign rd = cmd.valid && !cmd.wen;

  always_ff @(posedge clk) begin
    if (rst)
      rd_valid <= 1'b0;
    else
      rd_valid <= rd;
  end

  always_ff @(posedge clk) begin
    if (rd) begin
      case (cmd.idx)
        core_io_pkg::RD_DESC_L:     if (in_desc_valid) rd_data <= in_desc[31:0];
        core_io_pkg::RD_DESC_H:     if (in_desc_valid) rd_data <= in_desc[63:32];
        core_io_pkg::RD_DRAM_FLAGS: rd_data <= dram_flags;
        core_io_pkg::RD_STATUS:     rd_data <= {7'd0, core_msg_ready, 7'd0, slot_wr_ready,
                                                7'd0, out_desc_ready, 7'd0, in_desc_valid};
        core_io_pkg::RD_CORE_ID:    rd_data <= {24'd0, core_id};
        core_io_pkg::RD_TIMER_L:    rd_data <= timer[31:0];
        core_io_pkg::RD_TIMER_H:    rd_data <= timer[63:32];
        core_io_pkg::RD_INT_FLAGS:  rd_data <= int_flags;
        core_io_pkg::RD_MASK:       rd_data <= {16'd0, int_mask};
        core_io_pkg::RD_BC_MASK:    rd_data <= {{(32-BC_ADDR_W){1'b0}}, bc_mask};
        core_io_pkg::RD_BC_EQUAL:   rd_data <= {{(32-BC_ADDR_W){1'b0}}, bc_equal};
        core_io_pkg::RD_BC_HEAD:    rd_data <= {{(32-BC_ADDR_W){1'b0}}, bc_head};
        default:                    rd_data <= '0;
      endcase
    end
  end

endmodule

// File: event_unit.sv
`timescale 1ns/1ps

module event_unit #(
  parameter int BC_ADDR_W  = 15,
  parameter int BC_FIFO_AW = 4
) (
  input  logic                 clk,
  input  logic                 rst,
  input  core_io_pkg::io_ctl_t ctl,
  input  logic [4:0]           recv_tag,
  input  logic                 recv_tag_valid,
  input  logic [BC_ADDR_W-1:0] bc_addr_in,
  input  logic                 bc_valid_in,
  input  logic [BC_ADDR_W-1:0] bc_mask,
  input  logic [BC_ADDR_W-1:0] bc_equal,
  input  logic                 bc_fifo_en,
  output logic                 timer_int,
  output logic [31:0]          dram_flags,
  output logic                 dram_any,
  output logic                 bc_valid,
  output logic [BC_ADDR_W-1:0] bc_head,
  output logic                 bc_ovf_event
);

  typedef logic [BC_ADDR_W-1:0] bc_addr_t;

  logic [31:0] timer_step;
  logic [31:0] timer_cnt;
  logic [4:0]  tag_r;
  logic        tag_valid_r;
  bc_addr_t    bc_addr_r;
  logic        bc_hit_r;
  logic        fifo_in_ready;

  ////////////////////////////////////////////////////////////
  // Interval timer
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst)
      timer_step <= core_io_pkg::TIMER_STEP_RESET;
    else if (ctl.timer_restart)
      timer_step <= ctl.wr_data;
  end

  always_ff @(posedge clk) begin
    if (rst || ctl.timer_restart) begin
      timer_cnt <= '0;
      timer_int <= 1'b0;
    end else if (timer_cnt == timer_step) begin
      timer_cnt <= '0;
      timer_int <= 1'b1;
    end else begin
      timer_cnt <= timer_cnt + 1'b1;
      if (ctl.int_ack && ctl.wr_data[core_io_pkg::INT_TIMER])
        timer_int <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // DRAM receive flags
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    tag_r <= recv_tag;
    if (rst)
      tag_valid_r <= 1'b0;
    else
      tag_valid_r <= recv_tag_valid;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      dram_flags <= '0;
    end else begin
      if (ctl.flag_wr) begin
        for (int i = 0; i < 4; i++) begin
          if (ctl.flag_strb[i])
            dram_flags[i*8 +: 8] <= ctl.wr_data[i*8 +: 8];
        end
      end
      if (ctl.flag_clr)
        dram_flags[ctl.clr_tag] <= 1'b0;
      // Arrival overrides a clear of the same tag
      if (tag_valid_r)
        dram_flags[tag_r] <= 1'b1;
      dram_flags[0] <= 1'b0;
    end
  end

  assign dram_any = |dram_flags;

  ////////////////////////////////////////////////////////////
  // Broadcast filter and FIFO
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    bc_addr_r <= bc_addr_in;
    if (rst)
      bc_hit_r <= 1'b0;
    else
      bc_hit_r <= bc_valid_in && bc_fifo_en && ((bc_addr_in & bc_mask) == bc_equal);
  end

  msg_fifo #(
    .ADDR_W    (BC_FIFO_AW),
    .payload_t (bc_addr_t)
  ) bc_fifo (
    .clk       (clk),
    .rst       (rst),
    .clear     (!bc_fifo_en),
    .in_valid  (bc_hit_r),
    .in_data   (bc_addr_r),
    .in_ready  (fifo_in_ready),
    .out_valid (bc_valid),
    .out_data  (bc_head),
    .out_taken (ctl.bc_taken)
  );

  assign bc_ovf_event = bc_fifo_en && bc_hit_r && !fifo_in_ready;

  // Bit 0 never sets and every other arrival lands on its bit
  a_flag0_zero: assert property (@(posedge clk) disable iff (rst)
    !dram_flags[0] &&
    (!$past(tag_valid_r) || $past(tag_r) == 5'd0 || dram_flags[$past(tag_r)]))
    else $error("event_unit: DRAM flag bit 0 set or tag arrival lost");

endmodule

// File: io_write_regs.sv
`timescale 1ns/1ps

module io_write_regs #(
  parameter int BC_ADDR_W = 15
) (
  input  logic                 clk,
  input  logic                 rst,
  input  core_io_pkg::io_cmd_t cmd,
  input  logic                 out_desc_ready,
  output logic                 cmd_ready,
  output core_io_pkg::io_ctl_t ctl,
  output logic [15:0]          int_mask,
  output logic [BC_ADDR_W-1:0] bc_mask,
  output logic [BC_ADDR_W-1:0] bc_equal,
  output logic                 bc_fifo_en,
  output core_io_pkg::desc_t   out_desc,
  output logic                 out_desc_valid,
  output logic [63:0]          out_desc_dram_addr,
  output logic [31:0]          slot_wr_data,
  output logic                 slot_wr_valid,
  output logic                 in_desc_taken,
  output logic [63:0]          debug_out,
  output logic                 debug_l_valid,
  output logic                 debug_h_valid
);

  logic       wr;
  logic       desc_wr;
  logic [3:0] strb;

  // Byte lanes from access size and offset
  always_comb begin
    case (cmd.size)
      core_io_pkg::SIZE_BYTE: strb = 4'b0001 << cmd.byte_off;
      core_io_pkg::SIZE_HALF: strb = 4'b0011 << cmd.byte_off;
      default:                strb = 4'b1111;
    endcase
  end

  // Writes that touch the pending descriptor must wait for it to leave
  assign desc_wr = cmd.wen && ((cmd.idx == core_io_pkg::SEND_DESC_TYPE) ||
                               (cmd.idx == core_io_pkg::SEND_DESC_L) ||
                               (cmd.idx == core_io_pkg::SEND_DESC_H) ||
                               (cmd.idx == core_io_pkg::WR_DRAM_L) ||
                               (cmd.idx == core_io_pkg::WR_DRAM_H));

  assign cmd_ready = !(desc_wr && out_desc_valid && !out_desc_ready);
  assign wr        = cmd.valid && cmd.wen && cmd_ready;

  ////////////////////////////////////////////////////////////
  // Data registers
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (wr) begin
      for (int i = 0; i < 4; i++) begin
        if (strb[i]) begin
          case (cmd.idx)
            core_io_pkg::SEND_DESC_L: out_desc[i*8 +: 8] <= cmd.wr_data[i*8 +: 8];
            core_io_pkg::SEND_DESC_H: out_desc[32+i*8 +: 8] <= cmd.wr_data[i*8 +: 8];
            core_io_pkg::WR_DRAM_L:   out_desc_dram_addr[i*8 +: 8] <= cmd.wr_data[i*8 +: 8];
            core_io_pkg::WR_DRAM_H:   out_desc_dram_addr[32+i*8 +: 8] <= cmd.wr_data[i*8 +: 8];
            core_io_pkg::SLOT_DATA:   slot_wr_data[i*8 +: 8] <= cmd.wr_data[i*8 +: 8];
            core_io_pkg::DEBUG_L:     debug_out[i*8 +: 8] <= cmd.wr_data[i*8 +: 8];
            core_io_pkg::DEBUG_H:     debug_out[32+i*8 +: 8] <= cmd.wr_data[i*8 +: 8];
            default: ;
          endcase
        end
      end
      // Type write also launches the descriptor
      case (cmd.idx)
        core_io_pkg::SEND_DESC_TYPE: out_desc.dtype <= cmd.wr_data[3:0];
        core_io_pkg::BC_MASK_WR:     bc_mask <= cmd.wr_data[BC_ADDR_W-1:0];
        core_io_pkg::BC_EQUAL_WR:    bc_equal <= cmd.wr_data[BC_ADDR_W-1:0];
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Control state
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      int_mask       <= core_io_pkg::MASK_RESET;
      bc_fifo_en     <= 1'b0;
      out_desc_valid <= 1'b0;
      debug_l_valid  <= 1'b0;
      debug_h_valid  <= 1'b0;
    end else begin
      debug_l_valid <= wr && (cmd.idx == core_io_pkg::DEBUG_L);
      debug_h_valid <= wr && (cmd.idx == core_io_pkg::DEBUG_H);
      if (out_desc_valid && out_desc_ready)
        out_desc_valid <= 1'b0;
      // A new send in the same cycle as the handoff wins
      if (wr && (cmd.idx == core_io_pkg::SEND_DESC_TYPE))
        out_desc_valid <= 1'b1;
      if (wr && (cmd.idx == core_io_pkg::BC_FIFO_EN))
        bc_fifo_en <= cmd.wr_data[0];
      if (wr && (cmd.idx == core_io_pkg::MASK_WR)) begin
        for (int i = 0; i < 2; i++) begin
          if (strb[i])
            int_mask[i*8 +: 8] <= cmd.wr_data[i*8 +: 8];
        end
      end
    end
  end

  assign slot_wr_valid = wr && (cmd.idx == core_io_pkg::SLOT_STRB) && cmd.wr_data[0];
  assign in_desc_taken = wr && (cmd.idx == core_io_pkg::RD_DESC_STRB) && cmd.wr_data[0];

  always_comb begin
    ctl.timer_restart = wr && (cmd.idx == core_io_pkg::TIMER_STEP);
    ctl.flag_wr       = wr && (cmd.idx == core_io_pkg::DRAM_FLAGS_WR);
    ctl.flag_strb     = strb;
    ctl.flag_clr      = wr && (cmd.idx == core_io_pkg::DRAM_FLAG_CLR);
    ctl.clr_tag       = cmd.wr_data[4:0];
    ctl.bc_taken      = wr && (cmd.idx == core_io_pkg::BC_RD_STRB) && cmd.wr_data[0];
    ctl.int_ack       = wr && (cmd.idx == core_io_pkg::INT_ACK);
    ctl.wr_data       = cmd.wr_data;
  end

  // Descriptor and its contents are held until the consumer takes it
  a_desc_hold: assert property (@(posedge clk) disable iff (rst)
    out_desc_valid && !out_desc_ready |=> out_desc_valid && $stable(out_desc))
    else $error("io_write_regs: pending descriptor dropped or changed without ready");

endmodule

// File: msg_fifo.sv
`timescale 1ns/1ps

module msg_fifo #(
  parameter int  ADDR_W    = 4,
  parameter type payload_t = logic [7:0]
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     clear,
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     in_ready,
  output logic     out_valid,
  output payload_t out_data,
  input  logic     out_taken
);

  localparam int DEPTH = 2 ** ADDR_W;

  payload_t          mem [DEPTH];
  logic [ADDR_W-1:0] wr_ptr;
  logic [ADDR_W-1:0] rd_ptr;
  logic [ADDR_W:0]   count;
  logic              push;
  logic              pop;

  assign in_ready  = (count != DEPTH[ADDR_W:0]);
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];
  assign push      = in_valid && in_ready;
  assign pop       = out_taken && out_valid;

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      if (push && !pop)
        count <= count + 1'b1;
      else if (pop && !push)
        count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push)
      mem[wr_ptr] <= in_data;
  end

  // Reader only takes the head when there is one
  a_no_pop_empty: assert property (@(posedge clk) disable iff (rst || clear)
    out_taken |-> out_valid)
    else $error("msg_fifo: pop from empty FIFO");

endmodule

// File: core_io_pkg.sv
package core_io_pkg;

  typedef logic [5:0] reg_idx_t;

  ////////////////////////////////////////////////////////////
  // Write register indices
  ////////////////////////////////////////////////////////////
  localparam reg_idx_t SEND_DESC_L    = 6'd2;
  localparam reg_idx_t SEND_DESC_H    = 6'd3;
  localparam reg_idx_t WR_DRAM_L      = 6'd4;
  localparam reg_idx_t WR_DRAM_H      = 6'd5;
  localparam reg_idx_t SLOT_DATA      = 6'd6;
  localparam reg_idx_t TIMER_STEP     = 6'd7;
  localparam reg_idx_t DRAM_FLAGS_WR  = 6'd8;
  localparam reg_idx_t SEND_DESC_TYPE = 6'd10;
  localparam reg_idx_t RD_DESC_STRB   = 6'd11;
  localparam reg_idx_t DRAM_FLAG_CLR  = 6'd12;
  localparam reg_idx_t SLOT_STRB      = 6'd13;
  localparam reg_idx_t MASK_WR        = 6'd14;
  localparam reg_idx_t INT_ACK        = 6'd15;
  localparam reg_idx_t DEBUG_L        = 6'd16;
  localparam reg_idx_t DEBUG_H        = 6'd17;
  localparam reg_idx_t BC_MASK_WR     = 6'd18;
  localparam reg_idx_t BC_EQUAL_WR    = 6'd19;
  localparam reg_idx_t BC_FIFO_EN     = 6'd20;
  localparam reg_idx_t BC_RD_STRB     = 6'd21;

  ////////////////////////////////////////////////////////////
  // Read register indices
  ////////////////////////////////////////////////////////////
  localparam reg_idx_t RD_DESC_L      = 6'd32;
  localparam reg_idx_t RD_DESC_H      = 6'd33;
  localparam reg_idx_t RD_DRAM_FLAGS  = 6'd34;
  localparam reg_idx_t RD_STATUS      = 6'd35;
  localparam reg_idx_t RD_CORE_ID     = 6'd36;
  localparam reg_idx_t RD_TIMER_L     = 6'd37;
  localparam reg_idx_t RD_TIMER_H     = 6'd38;
  localparam reg_idx_t RD_INT_FLAGS   = 6'd39;
  localparam reg_idx_t RD_MASK        = 6'd40;
  localparam reg_idx_t RD_BC_MASK     = 6'd50;
  localparam reg_idx_t RD_BC_EQUAL    = 6'd51;
  localparam reg_idx_t RD_BC_HEAD     = 6'd52;

  // Interrupt flag bit positions
  localparam int INT_TIMER   = 0;
  localparam int INT_IN_DESC = 1;
  localparam int INT_DRAM    = 2;
  localparam int INT_BC_MSG  = 3;
  localparam int INT_POKE    = 4;
  localparam int INT_EVICT   = 5;
  localparam int INT_BC_OVF  = 8;
  localparam int INT_EXT_IO  = 9;

  localparam logic [15:0] MASK_RESET       = 16'hfff0;
  localparam logic [31:0] TIMER_STEP_RESET = 32'd1;

  // Access size codes, anything else is a full word
  localparam logic [1:0] SIZE_BYTE = 2'd0;
  localparam logic [1:0] SIZE_HALF = 2'd1;

  typedef struct packed {
    logic        valid;
    logic        wen;
    reg_idx_t    idx;
    logic [1:0]  byte_off;
    logic [1:0]  size;
    logic [31:0] wr_data;
  } io_cmd_t;

  // Single-cycle pulses from the write decoder
  typedef struct packed {
    logic        timer_restart;
    logic        flag_wr;
    logic [3:0]  flag_strb;
    logic        flag_clr;
    logic [4:0]  clr_tag;
    logic        bc_taken;
    logic        int_ack;
    logic [31:0] wr_data;
  } io_ctl_t;

  typedef struct packed {
    logic [3:0]  dtype;
    logic [59:0] data;
  } desc_t;

endpackage
